// File: rtl/wr_guard_macros.svh
// --------------------------------------------------------------------------
// write guard configuration defines: slot count, field widths,
// prescaler divide and budget base reset value
// --------------------------------------------------------------------------
`ifndef WR_GUARD_MACROS_SVH
`define WR_GUARD_MACROS_SVH

// outstanding writes tracked at once
`define WG_NUM_SLOTS 4

// AXI field widths
`define WG_ID_WIDTH 4
`define WG_LEN_WIDTH 8

// countdown width, counted in prescaler ticks
`define WG_BUDGET_WIDTH 12
`define WG_PRESCALE_LOG2 2
`define WG_BUDGET_BASE_RST 8

`endif

// File: rtl/wr_guard_pkg.sv
// --------------------------------------------------------------------------
// shared types of the write guard: slot index, AXI id and length,
// countdown budget and older same-id count
// --------------------------------------------------------------------------
`include "wr_guard_macros.svh"

package wr_guard_pkg;

  // slot number
  typedef logic [$clog2(`WG_NUM_SLOTS)-1:0] slot_idx_t;

  // AXI AW/B fields
  typedef logic [`WG_ID_WIDTH-1:0] axi_id_t;
  typedef logic [`WG_LEN_WIDTH-1:0] axi_len_t;

  // remaining ticks before a write times out
  typedef logic [`WG_BUDGET_WIDTH-1:0] budget_t;

  // older same-id writes still outstanding, up to the slot count
  typedef logic [$clog2(`WG_NUM_SLOTS+1)-1:0] ahead_t;

endpackage

// File: rtl/slot_alloc.sv
// --------------------------------------------------------------------------
// AW admission and slot allocation: handshake gating, lowest free slot,
// budget and same-id ahead count, prescaler tick
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "wr_guard_macros.svh"

module slot_alloc (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      aw_valid_i,
  input  logic                                      aw_ready_i,
  input  wr_guard_pkg::axi_id_t                     aw_id_i,
  input  wr_guard_pkg::axi_len_t                    aw_len_i,
  output logic                                      aw_valid_o,
  output logic                                      aw_ready_o,
  input  logic [`WG_NUM_SLOTS-1:0]                  slot_valid_i,
  input  wr_guard_pkg::axi_id_t [`WG_NUM_SLOTS-1:0] slot_id_i,
  input  logic                                      err_latched_i,
  input  wr_guard_pkg::budget_t                     budget_base_i,
  input  logic [`WG_NUM_SLOTS-1:0]                  retire_vec_i,
  output logic [`WG_NUM_SLOTS-1:0]                  alloc_vec_o,
  output wr_guard_pkg::axi_id_t                     alloc_id_o,
  output wr_guard_pkg::axi_len_t                    alloc_len_o,
  output wr_guard_pkg::budget_t                     alloc_budget_o,
  output wr_guard_pkg::ahead_t                      alloc_ahead_o,
  output logic                                      tick_o
);

  import wr_guard_pkg::*;

  logic                           admit;
  logic                           aw_fire;
  logic [`WG_NUM_SLOTS-1:0]       free_vec;
  logic [`WG_NUM_SLOTS-1:0]       pick_vec;
  logic [`WG_NUM_SLOTS-1:0]       same_id_vec;
  ahead_t                         same_cnt;
  logic [`WG_PRESCALE_LOG2-1:0]   presc_q;

  assign free_vec = ~slot_valid_i;
  assign admit    = (|free_vec) && !err_latched_i;

  // slave and master only see each other while admitted
  assign aw_valid_o = aw_valid_i & admit;
  assign aw_ready_o = aw_ready_i & admit;
  assign aw_fire    = aw_valid_i & aw_ready_i & admit;

  // lowest free slot wins
  always_comb begin
    pick_vec = '0;
    for (int i = `WG_NUM_SLOTS - 1; i >= 0; i--) begin
      if (free_vec[i]) begin
        pick_vec    = '0;
        pick_vec[i] = 1'b1;
      end
    end
  end

  // older writes of this id, not counting one that leaves now
  always_comb begin
    same_cnt = '0;
    for (int i = 0; i < `WG_NUM_SLOTS; i++) begin
      same_id_vec[i] = slot_valid_i[i] && (slot_id_i[i] == aw_id_i);
      if (same_id_vec[i]) begin
        same_cnt = same_cnt + ahead_t'(1);
      end
    end
    if (|(same_id_vec & retire_vec_i)) begin
      same_cnt = same_cnt - ahead_t'(1);
    end
  end

  assign alloc_vec_o    = aw_fire ? pick_vec : '0;
  assign alloc_id_o     = aw_id_i;
  assign alloc_len_o    = aw_len_i;
  assign alloc_ahead_o  = same_cnt;
  assign alloc_budget_o = budget_base_i + budget_t'(aw_len_i >> `WG_PRESCALE_LOG2)
                        + budget_t'(2);

  // free-running divider for the countdowns
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      presc_q <= '0;
    end else begin
      presc_q <= presc_q + 1'b1;
    end
  end

  assign tick_o = &presc_q;

  a_alloc_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(alloc_vec_o));

endmodule

// File: rtl/wr_slot.sv
// --------------------------------------------------------------------------
// one outstanding write tracker: id, length, countdown budget and
// older same-id count, cleared on retire or flush
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module wr_slot (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   alloc_i,
  input  wr_guard_pkg::axi_id_t  alloc_id_i,
  input  wr_guard_pkg::axi_len_t alloc_len_i,
  input  wr_guard_pkg::budget_t  alloc_budget_i,
  input  wr_guard_pkg::ahead_t   alloc_ahead_i,
  input  logic                   tick_i,
  input  logic                   retire_i,
  input  logic                   retire_any_i,
  input  wr_guard_pkg::axi_id_t  retire_id_i,
  input  logic                   flush_i,
  output logic                   valid_o,
  output wr_guard_pkg::axi_id_t  id_o,
  output wr_guard_pkg::axi_len_t len_o,
  output wr_guard_pkg::ahead_t   ahead_o,
  output logic                   expired_o
);

  import wr_guard_pkg::*;

  logic     valid_q;
  axi_id_t  id_q;
  axi_len_t len_q;
  budget_t  budget_q;
  ahead_t   ahead_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (alloc_i) begin
      valid_q  <= 1'b1;
      id_q     <= alloc_id_i;
      len_q    <= alloc_len_i;
      budget_q <= alloc_budget_i;
      ahead_q  <= alloc_ahead_i;
    end else if (retire_i) begin
      valid_q <= 1'b0;
    end else if (valid_q) begin
      // hold at zero, the matcher flushes on expiry
      if (tick_i && (budget_q != '0)) begin
        budget_q <= budget_q - budget_t'(1);
      end
      // an older write of our id just completed
      if (retire_any_i && (retire_id_i == id_q) && (ahead_q != '0)) begin
        ahead_q <= ahead_q - ahead_t'(1);
      end
    end
  end

  assign valid_o   = valid_q;
  assign id_o      = id_q;
  assign len_o     = len_q;
  assign ahead_o   = ahead_q;
  assign expired_o = valid_q && (budget_q == '0);

  a_no_alloc_busy : assert property (@(posedge clk_i) disable iff (reset_i)
    alloc_i |-> !valid_q);

endmodule

// File: rtl/rsp_matcher.sv
// --------------------------------------------------------------------------
// B response matching: head slot lookup per id, timeout and unwanted
// response detection, flush and error reporting
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "wr_guard_macros.svh"

module rsp_matcher (
  input  logic                                       b_valid_i,
  input  logic                                       b_ready_i,
  input  wr_guard_pkg::axi_id_t                      b_id_i,
  input  logic [`WG_NUM_SLOTS-1:0]                   slot_valid_i,
  input  wr_guard_pkg::axi_id_t [`WG_NUM_SLOTS-1:0]  slot_id_i,
  input  wr_guard_pkg::axi_len_t [`WG_NUM_SLOTS-1:0] slot_len_i,
  input  wr_guard_pkg::ahead_t [`WG_NUM_SLOTS-1:0]   slot_ahead_i,
  input  logic [`WG_NUM_SLOTS-1:0]                   slot_expired_i,
  output logic [`WG_NUM_SLOTS-1:0]                   retire_vec_o,
  output wr_guard_pkg::axi_id_t                      retire_id_o,
  output logic                                       flush_o,
  output logic                                       err_timeout_set_o,
  output logic                                       err_unwanted_set_o,
  output wr_guard_pkg::axi_id_t                      err_id_o,
  output wr_guard_pkg::axi_len_t                     retire_len_o
);

  import wr_guard_pkg::*;

  logic                     b_fire;
  logic                     timeout;
  logic [`WG_NUM_SLOTS-1:0] head_vec;
  slot_idx_t                exp_idx;
  axi_len_t                 head_len;
  logic                     head_dup;

  assign b_fire  = b_valid_i & b_ready_i;
  assign timeout = |slot_expired_i;

  // head of the b_id queue, and lowest expired slot
  always_comb begin
    head_len = '0;
    exp_idx  = '0;
    for (int i = `WG_NUM_SLOTS - 1; i >= 0; i--) begin
      head_vec[i] = slot_valid_i[i] && (slot_id_i[i] == b_id_i) && (slot_ahead_i[i] == '0);
      if (head_vec[i]) begin
        head_len = head_len | slot_len_i[i];
      end
      if (slot_expired_i[i]) begin
        exp_idx = slot_idx_t'(i);
      end
    end
  end

  // a B in the same cycle as a timeout is dropped
  assign retire_vec_o       = (b_fire && !timeout) ? head_vec : '0;
  assign retire_id_o        = b_id_i;
  assign retire_len_o       = head_len;
  assign err_timeout_set_o  = timeout;
  assign err_unwanted_set_o = b_fire && !timeout && !(|head_vec);
  assign flush_o            = err_timeout_set_o | err_unwanted_set_o;
  assign err_id_o           = timeout ? slot_id_i[exp_idx] : b_id_i;

  // each id queue has exactly one head
  always_comb begin
    head_dup = 1'b0;
    for (int i = 0; i < `WG_NUM_SLOTS; i++) begin
      for (int j = i + 1; j < `WG_NUM_SLOTS; j++) begin
        if (slot_valid_i[i] && slot_valid_i[j] && (slot_id_i[i] == slot_id_i[j]) &&
            (slot_ahead_i[i] == '0) && (slot_ahead_i[j] == '0)) begin
          head_dup = 1'b1;
        end
      end
    end
    a_single_head : assert final (head_dup !== 1'b1);
  end

endmodule

// File: rtl/guard_regs.sv
// --------------------------------------------------------------------------
// Wishbone classic register file: STATUS, ERR_ID, LAST_LEN, BUDGET_BASE,
// single-cycle ack and interrupt
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "wr_guard_macros.svh"

module guard_regs (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [1:0]             wb_adr_i,
  input  logic [31:0]            wb_dat_i,
  output logic [31:0]            wb_dat_o,
  output logic                   wb_ack_o,
  input  logic                   err_timeout_set_i,
  input  logic                   err_unwanted_set_i,
  input  wr_guard_pkg::axi_id_t  err_id_i,
  input  logic                   retire_valid_i,
  input  wr_guard_pkg::axi_len_t retire_len_i,
  output logic                   err_latched_o,
  output wr_guard_pkg::budget_t  budget_base_o,
  output logic                   irq_o
);

  import wr_guard_pkg::*;

  localparam logic [1:0] ADR_STATUS      = 2'd0;
  localparam logic [1:0] ADR_ERR_ID      = 2'd1;
  localparam logic [1:0] ADR_LAST_LEN    = 2'd2;
  localparam logic [1:0] ADR_BUDGET_BASE = 2'd3;

  logic       req;
  logic       ack_q;
  logic       served_q;
  logic       wr_en;
  logic [1:0] status_clr;
  logic [1:0] status_q;
  axi_id_t    err_id_q;
  axi_len_t   last_len_q;
  budget_t    budget_base_q;

  // one ack per request until cyc/stb drop
  assign req   = wb_cyc_i & wb_stb_i;
  assign wr_en = req & wb_we_i & ~ack_q & ~served_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q    <= 1'b0;
      served_q <= 1'b0;
    end else begin
      ack_q    <= req & ~ack_q & ~served_q;
      served_q <= req & (served_q | ack_q);
    end
  end

  // write 1 to clear
  // a new error wins over the clear
  assign status_clr = (wr_en && (wb_adr_i == ADR_STATUS)) ? wb_dat_i[1:0] : 2'b00;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      status_q      <= 2'b00;
      err_id_q      <= '0;
      last_len_q    <= '0;
      budget_base_q <= budget_t'(`WG_BUDGET_BASE_RST);
    end else begin
      status_q <= (status_q & ~status_clr) | {err_unwanted_set_i, err_timeout_set_i};
      // first error of an episode keeps its id
      if ((err_timeout_set_i || err_unwanted_set_i) && !(|status_q)) begin
        err_id_q <= err_id_i;
      end
      if (retire_valid_i) begin
        last_len_q <= retire_len_i;
      end
      if (wr_en && (wb_adr_i == ADR_BUDGET_BASE)) begin
        budget_base_q <= wb_dat_i[`WG_BUDGET_WIDTH-1:0];
      end
    end
  end

  always_comb begin
    case (wb_adr_i)
      ADR_STATUS:   wb_dat_o = {30'd0, status_q};
      ADR_ERR_ID:   wb_dat_o = {{(32-`WG_ID_WIDTH){1'b0}}, err_id_q};
      ADR_LAST_LEN: wb_dat_o = {{(32-`WG_LEN_WIDTH){1'b0}}, last_len_q};
      default:      wb_dat_o = {{(32-`WG_BUDGET_WIDTH){1'b0}}, budget_base_q};
    endcase
  end

  assign wb_ack_o      = ack_q;
  assign err_latched_o = |status_q;
  assign irq_o         = |status_q;
  assign budget_base_o = budget_base_q;

  a_ack_needs_req : assert property (@(posedge clk_i) disable iff (reset_i)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i));

endmodule

// File: rtl/wr_guard_top.sv
// --------------------------------------------------------------------------
// AXI write watchdog top: allocator, slot tracker array, response
// matcher and Wishbone register file
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "wr_guard_macros.svh"

module wr_guard_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   aw_valid_i,
  input  logic                   aw_ready_i,
  input  wr_guard_pkg::axi_id_t  aw_id_i,
  input  wr_guard_pkg::axi_len_t aw_len_i,
  output logic                   aw_valid_o,
  output logic                   aw_ready_o,
  input  logic                   b_valid_i,
  input  logic                   b_ready_i,
  input  wr_guard_pkg::axi_id_t  b_id_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [1:0]             wb_adr_i,
  input  logic [31:0]            wb_dat_i,
  output logic [31:0]            wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   irq_o
);

  import wr_guard_pkg::*;

  logic [`WG_NUM_SLOTS-1:0]     alloc_vec;
  axi_id_t                      alloc_id;
  axi_len_t                     alloc_len;
  budget_t                      alloc_budget;
  ahead_t                       alloc_ahead;
  logic                         tick;
  logic [`WG_NUM_SLOTS-1:0]     slot_valid;
  axi_id_t [`WG_NUM_SLOTS-1:0]  slot_id;
  axi_len_t [`WG_NUM_SLOTS-1:0] slot_len;
  ahead_t [`WG_NUM_SLOTS-1:0]   slot_ahead;
  logic [`WG_NUM_SLOTS-1:0]     slot_expired;
  logic [`WG_NUM_SLOTS-1:0]     retire_vec;
  logic                         retire_any;
  axi_id_t                      retire_id;
  axi_len_t                     retire_len;
  logic                         flush;
  logic                         err_timeout_set;
  logic                         err_unwanted_set;
  axi_id_t                      err_id;
  logic                         err_latched;
  budget_t                      budget_base;

  assign retire_any = |retire_vec;

  slot_alloc i_slot_alloc (
    .clk_i, .reset_i, .aw_valid_i, .aw_ready_i, .aw_id_i, .aw_len_i,
    .aw_valid_o, .aw_ready_o,
    .slot_valid_i   (slot_valid),
    .slot_id_i      (slot_id),
    .err_latched_i  (err_latched),
    .budget_base_i  (budget_base),
    .retire_vec_i   (retire_vec),
    .alloc_vec_o    (alloc_vec),
    .alloc_id_o     (alloc_id),
    .alloc_len_o    (alloc_len),
    .alloc_budget_o (alloc_budget),
    .alloc_ahead_o  (alloc_ahead),
    .tick_o         (tick)
  );

  for (genvar i = 0; i < `WG_NUM_SLOTS; i++) begin : g_slot
    wr_slot i_wr_slot (
      .clk_i, .reset_i,
      .alloc_i        (alloc_vec[i]),
      .alloc_id_i     (alloc_id),
      .alloc_len_i    (alloc_len),
      .alloc_budget_i (alloc_budget),
      .alloc_ahead_i  (alloc_ahead),
      .tick_i         (tick),
      .retire_i       (retire_vec[i]),
      .retire_any_i   (retire_any),
      .retire_id_i    (retire_id),
      .flush_i        (flush),
      .valid_o        (slot_valid[i]),
      .id_o           (slot_id[i]),
      .len_o          (slot_len[i]),
      .ahead_o        (slot_ahead[i]),
      .expired_o      (slot_expired[i])
    );
  end

  rsp_matcher i_rsp_matcher (
    .b_valid_i, .b_ready_i, .b_id_i,
    .slot_valid_i       (slot_valid),
    .slot_id_i          (slot_id),
    .slot_len_i         (slot_len),
    .slot_ahead_i       (slot_ahead),
    .slot_expired_i     (slot_expired),
    .retire_vec_o       (retire_vec),
    .retire_id_o        (retire_id),
    .flush_o            (flush),
    .err_timeout_set_o  (err_timeout_set),
    .err_unwanted_set_o (err_unwanted_set),
    .err_id_o           (err_id),
    .retire_len_o       (retire_len)
  );

  guard_regs i_guard_regs (
    .clk_i, .reset_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .wb_dat_o, .wb_ack_o,
    .err_timeout_set_i  (err_timeout_set),
    .err_unwanted_set_i (err_unwanted_set),
    .err_id_i           (err_id),
    .retire_valid_i     (retire_any),
    .retire_len_i       (retire_len),
    .err_latched_o      (err_latched),
    .budget_base_o      (budget_base),
    .irq_o
  );

endmodule

// File: verification/tb_clk_gen.sv
// --------------------------------------------------------------------------
// testbench clock (10 ns period) and reset held for 8 cycles
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (8) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// File: verification/wr_guard_tb.sv
// --------------------------------------------------------------------------
// write guard testbench: LFSR stimulus, per-id write model, Wishbone
// register tasks, concurrent checks, cycle watchdog and verdict
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "wr_guard_macros.svh"

module wr_guard_tb;

  import wr_guard_pkg::*;

  localparam int ID_W = `WG_ID_WIDTH;
  localparam int LEN_W = `WG_LEN_WIDTH;
  localparam int TICK_CYC = 1 << `WG_PRESCALE_LOG2;
  localparam int BIG_BASE = 120;
  localparam int MAX_BUDGET = BIG_BASE + (255 >> `WG_PRESCALE_LOG2) + 2;
  localparam int TEST_PHASES = 12;
  localparam int CYCLE_LIMIT = TEST_PHASES * MAX_BUDGET * 4 + 500;

  logic clk_i, reset_i;
  logic aw_valid_i, aw_ready_i, aw_valid_o, aw_ready_o;
  axi_id_t aw_id_i, b_id_i;
  axi_len_t aw_len_i;
  logic b_valid_i, b_ready_i;
  logic wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o, irq_o;
  logic [1:0] wb_adr_i;
  logic [31:0] wb_dat_i, wb_dat_o;

  // model entries are {id, len}, oldest first
  logic [ID_W+LEN_W-1:0] pend_q [$];
  int outstanding = 0;
  logic [31:0] lfsr_q = 32'h197;
  logic rd_chk = 1'b0;
  logic [31:0] rd_exp = '0;
  logic irq_expect = 1'b0;
  logic tmo_armed = 1'b0;
  int tmo_cnt = 0;
  int tmo_lo = 0;
  int tmo_hi = 0;
  int cycle_cnt = 0;
  int fail_cnt = 0;

  tb_clk_gen i_tb_clk_gen (.clk_o(clk_i), .reset_o(reset_i));

  wr_guard_top i_wr_guard_top (.*);

  task automatic report_error(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    fail_cnt++;
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = rand_bits(1);
    return r[0];
  endfunction

  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                           input logic chk);
    @(negedge clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    rd_chk = chk;
    do @(posedge clk_i); while (!wb_ack_o);
    @(negedge clk_i);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    rd_chk = 1'b0;
  endtask

  task automatic reg_read(input logic [1:0] adr, input logic [31:0] exp_val);
    rd_exp = exp_val;
    wb_access(1'b0, adr, '0, 1'b1);
  endtask

  task automatic reg_write(input logic [1:0] adr, input logic [31:0] val);
    wb_access(1'b1, adr, val, 1'b0);
  endtask

  // retries until the gated handshake fires, bp adds random back-pressure
  task automatic issue_write(input axi_id_t id, input axi_len_t len, input logic bp);
    logic fired;
    fired = 1'b0;
    while (!fired) begin
      @(negedge clk_i);
      aw_valid_i = 1'b1;
      aw_id_i = id;
      aw_len_i = len;
      aw_ready_i = bp ? rand_bit() : 1'b1;
      @(posedge clk_i);
      fired = aw_valid_o && aw_ready_o;
    end
    pend_q.push_back({id, len});
    outstanding = pend_q.size();
    @(negedge clk_i);
    aw_valid_i = 1'b0;
    aw_ready_i = rand_bit();
  endtask

  task automatic press_aw(input int cycles);
    @(negedge clk_i);
    aw_valid_i = 1'b1;
    aw_ready_i = 1'b1;
    aw_id_i = axi_id_t'(rand_bits(ID_W));
    repeat (cycles) @(negedge clk_i);
    aw_valid_i = 1'b0;
  endtask

  task automatic send_b(input axi_id_t id);
    @(negedge clk_i);
    b_valid_i = 1'b1;
    b_ready_i = 1'b1;
    b_id_i = id;
    @(negedge clk_i);
    b_valid_i = 1'b0;
    b_ready_i = rand_bit();
  endtask

  // answer a random id, LAST_LEN must show that id's oldest write
  task automatic retire_one();
    int head;
    axi_id_t id;
    axi_len_t exp_len;
    head = int'(rand_bits(8)) % pend_q.size();
    id = pend_q[head][ID_W+LEN_W-1:LEN_W];
    for (int k = pend_q.size() - 1; k >= 0; k--) begin
      if (pend_q[k][ID_W+LEN_W-1:LEN_W] == id) head = k;
    end
    exp_len = pend_q[head][LEN_W-1:0];
    pend_q.delete(head);
    send_b(id);
    outstanding = pend_q.size();
    reg_read(2'd2, 32'(exp_len));
  endtask

  task automatic clear_status();
    reg_write(2'd0, 32'h3);
    irq_expect = 1'b0;
    reg_read(2'd0, 32'h0);
  endtask

  task automatic wait_irq();
    do @(posedge clk_i); while (!irq_o);
    @(negedge clk_i);
    tmo_armed = 1'b0;
    pend_q.delete();
    outstanding = 0;
  endtask

  task automatic run_timeout(input int base);
    axi_id_t id;
    axi_len_t len;
    int budget;
    id = axi_id_t'(rand_bits(ID_W));
    len = axi_len_t'(rand_bits(LEN_W));
    budget = base + (int'(len) >> `WG_PRESCALE_LOG2) + 2;
    tmo_lo = budget * TICK_CYC;
    tmo_hi = (budget + 1) * TICK_CYC + 3;
    irq_expect = 1'b1;
    issue_write(id, len, 1'b0);
    // edges counted from the fire cycle, fire edge is number 1
    tmo_cnt = 2;
    tmo_armed = 1'b1;
    wait_irq();
    reg_read(2'd0, 32'h1);
    reg_read(2'd1, 32'(id));
    clear_status();
  endtask

  always @(posedge clk_i) begin
    if (tmo_armed) tmo_cnt <= tmo_cnt + 1;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Regression failed");
      $fatal(1, "timeout: the test did not finish within %0d cycles", CYCLE_LIMIT);
    end
  end

  a_aw_pass : assert property (@(posedge clk_i) disable iff (reset_i)
    (!irq_o && outstanding < `WG_NUM_SLOTS) |->
      (aw_valid_o == aw_valid_i && aw_ready_o == aw_ready_i))
    else report_error("AW handshake not passed through while slots are free");
  a_aw_full : assert property (@(posedge clk_i) disable iff (reset_i)
    (outstanding >= `WG_NUM_SLOTS) |-> !aw_ready_o)
    else report_error("aw_ready_o high with all slots in use");
  a_err_block : assert property (@(posedge clk_i) disable iff (reset_i)
    irq_o |-> (!aw_ready_o && !aw_valid_o))
    else report_error("AW admitted while an error is latched");
  a_irq_quiet : assert property (@(posedge clk_i) disable iff (reset_i)
    !irq_expect |-> !irq_o)
    else report_error("unexpected irq_o");
  a_rd_data : assert property (@(posedge clk_i) disable iff (reset_i)
    (rd_chk && wb_ack_o) |-> (wb_dat_o == rd_exp))
    else report_error($sformatf("register read %0h, expected %0h", $sampled(wb_dat_o), rd_exp));
  a_tmo_early : assert property (@(posedge clk_i) disable iff (reset_i)
    (tmo_armed && $rose(irq_o)) |-> (tmo_cnt >= tmo_lo))
    else report_error("timeout flagged before the budget ran out");
  a_tmo_late : assert property (@(posedge clk_i) disable iff (reset_i)
    (tmo_armed && !irq_o) |-> (tmo_cnt <= tmo_hi))
    else report_error("timeout not flagged within the budget bound");

  initial begin
    axi_id_t id_a;
    axi_len_t len_a;
    aw_valid_i = 1'b0;
    aw_ready_i = 1'b0;
    aw_id_i = '0;
    aw_len_i = '0;
    b_valid_i = 1'b0;
    b_ready_i = 1'b0;
    b_id_i = '0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wait (reset_i === 1'b0);
    reg_read(2'd3, 32'(`WG_BUDGET_BASE_RST));
    reg_write(2'd3, 32'(BIG_BASE));
    reg_read(2'd3, 32'(BIG_BASE));
    // fill every slot, hold AW while full, then answer in random id order
    repeat (3) begin
      repeat (`WG_NUM_SLOTS) issue_write(axi_id_t'(rand_bits(ID_W)),
                                         axi_len_t'(rand_bits(LEN_W)), 1'b1);
      press_aw(4);
      while (pend_q.size() != 0) retire_one();
    end
    // same id twice around another id
    id_a = axi_id_t'(rand_bits(ID_W));
    len_a = axi_len_t'(rand_bits(LEN_W));
    issue_write(id_a, len_a, 1'b1);
    issue_write(id_a + 1'b1, axi_len_t'(rand_bits(LEN_W)), 1'b1);
    issue_write(id_a, len_a + axi_len_t'(rand_bits(5)) + 1'b1, 1'b1);
    while (pend_q.size() != 0) retire_one();
    // B with no outstanding write
    id_a = axi_id_t'(rand_bits(ID_W));
    irq_expect = 1'b1;
    send_b(id_a);
    wait_irq();
    reg_read(2'd0, 32'h2);
    reg_read(2'd1, 32'(id_a));
    press_aw(4);
    clear_status();
    issue_write(axi_id_t'(rand_bits(ID_W)), axi_len_t'(rand_bits(LEN_W)), 1'b1);
    retire_one();
    run_timeout(BIG_BASE);
    reg_write(2'd3, 32'(`WG_BUDGET_BASE_RST));
    reg_read(2'd3, 32'(`WG_BUDGET_BASE_RST));
    run_timeout(`WG_BUDGET_BASE_RST);
    issue_write(axi_id_t'(rand_bits(ID_W)), axi_len_t'(rand_bits(LEN_W)), 1'b1);
    retire_one();
    repeat (4) @(negedge clk_i);
    if (fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+rtl
rtl/wr_guard_pkg.sv
rtl/slot_alloc.sv
rtl/wr_slot.sv
rtl/rsp_matcher.sv
rtl/guard_regs.sv
rtl/wr_guard_top.sv
verification/tb_clk_gen.sv
verification/wr_guard_tb.sv
